//--- noc_pkg.sv
package noc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Flit and channel geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DATA_WIDTH = 32;
    localparam int CHANNELS   = 5;
    localparam int CH_W       = 3;

    typedef logic [DATA_WIDTH-1:0] flit_t;  // One flit payload
    typedef logic [CH_W-1:0]       chan_t;  // Router port index

    localparam chan_t PORT_LOCAL = 3'd0;
    localparam chan_t PORT_NORTH = 3'd1;
    localparam chan_t PORT_EAST  = 3'd2;
    localparam chan_t PORT_SOUTH = 3'd3;
    localparam chan_t PORT_WEST  = 3'd4;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Mesh coordinates and header layout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int MESH_X  = 4;
    localparam int MESH_Y  = 4;
    localparam int COORD_W = 2;

    typedef logic [COORD_W-1:0] coord_t;    // One mesh coordinate

    localparam int HDR_X_LSB = 0;           // Target x in header bits 1:0
    localparam int HDR_Y_LSB = 2;           // Target y in header bits 3:2

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input buffering
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int BUFFER_LENGTH = 2;
    localparam int FIFO_PTR_W    = $clog2(BUFFER_LENGTH);
    localparam int FIFO_CNT_W    = $clog2(BUFFER_LENGTH + 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Arbiter FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [0:0] {
        ARB_IDLE,                           // Waiting for a header
        ARB_FORWARD                         // Packet in flight
    } arb_state_t;

endpackage

//--- flit_fifo.sv
`timescale 1ns/1ps

module flit_fifo
    import noc_pkg::*;
(
    input  logic  clk,
    input  logic  rst_i,

    input  flit_t wr_data_i,
    input  logic  wr_last_i,
    input  logic  wr_valid_i,
    output logic  wr_ready_o,

    output flit_t rd_data_o,
    output logic  rd_last_o,
    output logic  rd_valid_o,
    input  logic  rd_ready_i
);

    flit_t mem_data [BUFFER_LENGTH];
    logic  mem_last [BUFFER_LENGTH];

    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;

    logic do_wr;
    logic do_rd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rd_valid_o = (count != '0);
    assign wr_ready_o = (count != FIFO_CNT_W'(BUFFER_LENGTH)) || rd_ready_i;  // Full but draining

    assign do_wr = wr_valid_i && wr_ready_o;
    assign do_rd = rd_valid_o && rd_ready_i;

    assign rd_data_o = mem_data[rd_ptr];
    assign rd_last_o = mem_last[rd_ptr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage and pointers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_data[wr_ptr] <= wr_data_i;
            mem_last[wr_ptr] <= wr_last_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(BUFFER_LENGTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == FIFO_PTR_W'(BUFFER_LENGTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle or simultaneous push/pop
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst_i)
        (count == FIFO_CNT_W'(BUFFER_LENGTH) && !do_rd) |=>
            (count == FIFO_CNT_W'(BUFFER_LENGTH)) && $stable(wr_ptr))
        else $error("flit_fifo write accepted while full without a read");

endmodule

//--- packet_arbiter.sv
`timescale 1ns/1ps

module packet_arbiter
    import noc_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_i,

    input  flit_t [CHANNELS-1:0] q_data_i,
    input  logic  [CHANNELS-1:0] q_last_i,
    input  logic  [CHANNELS-1:0] q_valid_i,
    output logic  [CHANNELS-1:0] q_ready_o,

    output flit_t                sel_data_o,
    output logic                 sel_last_o,
    output logic                 sel_valid_o,
    input  logic                 sel_ready_i,

    output coord_t               target_x_o,
    output coord_t               target_y_o
);

    arb_state_t state;
    chan_t      grant;
    chan_t      rr_ptr;     // First channel to look at on the next pick

    logic       pick_found;
    chan_t      pick_idx;
    chan_t      rr_next;
    logic       last_xfer;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin search starting at rr_ptr
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        pick_found = 1'b0;
        pick_idx   = rr_ptr;
        for (int k = 0; k < CHANNELS; k++) begin
            automatic int idx = (int'(rr_ptr) + k) % CHANNELS;
            if (!pick_found && q_valid_i[idx]) begin
                pick_found = 1'b1;
                pick_idx   = chan_t'(idx);
            end
        end
    end

    assign rr_next = (pick_idx == chan_t'(CHANNELS - 1)) ? PORT_LOCAL : pick_idx + 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Forward path to the switch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign sel_data_o  = q_data_i[grant];
    assign sel_last_o  = q_last_i[grant];
    assign sel_valid_o = (state == ARB_FORWARD) && q_valid_i[grant];

    always_comb begin
        q_ready_o = '0;
        if (state == ARB_FORWARD) begin
            q_ready_o[grant] = sel_ready_i;     // Only the granted FIFO drains
        end
    end

    assign last_xfer = sel_valid_o && sel_ready_i && sel_last_o;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state  <= ARB_IDLE;
            grant  <= PORT_LOCAL;
            rr_ptr <= PORT_LOCAL;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_found) begin
                        state  <= ARB_FORWARD;
                        grant  <= pick_idx;
                        rr_ptr <= rr_next;          // Winner goes to the back
                    end
                end
                ARB_FORWARD: begin
                    if (last_xfer) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Header fields, latched while the header still sits at the FIFO head
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && pick_found) begin
            target_x_o <= q_data_i[pick_idx][HDR_X_LSB +: COORD_W];
            target_y_o <= q_data_i[pick_idx][HDR_Y_LSB +: COORD_W];
        end
    end

    a_grant_range: assert property (@(posedge clk) disable iff (rst_i)
        (state == ARB_FORWARD) |-> (grant < CHANNELS))
        else $error("packet_arbiter grant out of range");

    a_ready_onehot: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0(q_ready_o))
        else $error("packet_arbiter drains more than one FIFO");

endmodule

//--- xy_route_switch.sv
`timescale 1ns/1ps

module xy_route_switch
    import noc_pkg::*;
#(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
)(
    input  flit_t                sel_data_i,
    input  logic                 sel_last_i,
    input  logic                 sel_valid_i,
    output logic                 sel_ready_o,

    input  coord_t               target_x_i,
    input  coord_t               target_y_i,

    output flit_t [CHANNELS-1:0] out_data_o,
    output logic  [CHANNELS-1:0] out_last_o,
    output logic  [CHANNELS-1:0] out_valid_o,
    input  logic  [CHANNELS-1:0] out_ready_i
);

    chan_t  route_port;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // XY routing with x resolved before y
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        if (target_x_i > coord_t'(ROUTER_X)) begin
            route_port = PORT_EAST;
        end else if (target_x_i < coord_t'(ROUTER_X)) begin
            route_port = PORT_WEST;
        end else if (target_y_i > coord_t'(ROUTER_Y)) begin
            route_port = PORT_NORTH;
        end else if (target_y_i < coord_t'(ROUTER_Y)) begin
            route_port = PORT_SOUTH;
        end else begin
            route_port = PORT_LOCAL;        // Arrived
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output demux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        for (int p = 0; p < CHANNELS; p++) begin
            out_data_o[p] = sel_data_i;     // Payload fans out and valid qualifies it
            out_last_o[p] = sel_last_i;
        end
    end

    always_comb begin
        out_valid_o             = '0;
        out_valid_o[route_port] = sel_valid_i;
    end

    assign sel_ready_o = out_ready_i[route_port];

    // Downstream must only ever see one active output
    always_comb begin
        a_valid_onehot: assert final ($onehot0(out_valid_o))
            else $error("xy_route_switch drives more than one output");
    end

endmodule

//--- mesh_router.sv
`timescale 1ns/1ps

module mesh_router
    import noc_pkg::*;
#(
    parameter int ROUTER_X = 1,
    parameter int ROUTER_Y = 1
)(
    input  logic                 clk,
    input  logic                 rst_i,

    input  flit_t [CHANNELS-1:0] in_data_i,
    input  logic  [CHANNELS-1:0] in_last_i,
    input  logic  [CHANNELS-1:0] in_valid_i,
    output logic  [CHANNELS-1:0] in_ready_o,

    output flit_t [CHANNELS-1:0] out_data_o,
    output logic  [CHANNELS-1:0] out_last_o,
    output logic  [CHANNELS-1:0] out_valid_o,
    input  logic  [CHANNELS-1:0] out_ready_i
);

    flit_t [CHANNELS-1:0] q_data;
    logic  [CHANNELS-1:0] q_last;
    logic  [CHANNELS-1:0] q_valid;
    logic  [CHANNELS-1:0] q_ready;

    flit_t  sel_data;
    logic   sel_last;
    logic   sel_valid;
    logic   sel_ready;
    coord_t target_x;
    coord_t target_y;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input buffers, one per channel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < CHANNELS; i++) begin : g_in_fifo
        flit_fifo u_fifo (
            .clk        (clk),
            .rst_i      (rst_i),
            .wr_data_i  (in_data_i[i]),
            .wr_last_i  (in_last_i[i]),
            .wr_valid_i (in_valid_i[i]),
            .wr_ready_o (in_ready_o[i]),
            .rd_data_o  (q_data[i]),
            .rd_last_o  (q_last[i]),
            .rd_valid_o (q_valid[i]),
            .rd_ready_i (q_ready[i])
        );
    end

    packet_arbiter u_arbiter (
        .clk         (clk),
        .rst_i       (rst_i),
        .q_data_i    (q_data),
        .q_last_i    (q_last),
        .q_valid_i   (q_valid),
        .q_ready_o   (q_ready),
        .sel_data_o  (sel_data),
        .sel_last_o  (sel_last),
        .sel_valid_o (sel_valid),
        .sel_ready_i (sel_ready),
        .target_x_o  (target_x),
        .target_y_o  (target_y)
    );

    xy_route_switch #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) u_switch (
        .sel_data_i  (sel_data),
        .sel_last_i  (sel_last),
        .sel_valid_i (sel_valid),
        .sel_ready_o (sel_ready),
        .target_x_i  (target_x),
        .target_y_i  (target_y),
        .out_data_o  (out_data_o),
        .out_last_o  (out_last_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

endmodule

//--- tb_mesh_router.sv
`timescale 1ns/1ps

module tb_mesh_router
    import noc_pkg::*;
;

    localparam int ROUTER_X  = 1;
    localparam int ROUTER_Y  = 1;
    localparam int SRC_LSB   = 4;           // Source id sits above the target in a header
    localparam int MEM_DEPTH = 256;         // Flits per source over the whole run
    localparam int SEED      = 32'h7e33;

    logic                 clk         = 1'b0;
    logic                 rst_i       = 1'b1;
    flit_t [CHANNELS-1:0] in_data_i   = '0;
    logic  [CHANNELS-1:0] in_last_i   = '0;
    logic  [CHANNELS-1:0] in_valid_i  = '0;
    logic  [CHANNELS-1:0] in_ready_o;
    flit_t [CHANNELS-1:0] out_data_o;
    logic  [CHANNELS-1:0] out_last_o;
    logic  [CHANNELS-1:0] out_valid_o;
    logic  [CHANNELS-1:0] out_ready_i = '1;

    // Per source flit list {port, last, data} read by both the sender and the scoreboard
    logic [CH_W+DATA_WIDTH:0] pkt_mem [CHANNELS][MEM_DEPTH];
    int fill_ptr [CHANNELS] = '{default: 0};
    int send_ptr [CHANNELS] = '{default: 0};
    int rx_ptr   [CHANNELS] = '{default: 0};

    logic [CHANNELS-1:0] in_accept  = '0;
    logic                rand_ready = 1'b0;
    logic                idle_check = 1'b0;
    logic                expect_hdr = 1'b1;
    int                  cur_src    = 0;
    integer              pkt_seed   = SEED;
    integer              sink_seed  = SEED ^ 32'h5a5a;
    logic [31:0]         sink_bits;

    int total_flits = 0;
    int cycles      = 0;
    int checks      = 0;
    int errors      = 0;
    int check_mark  = 0;
    int err_mark    = 0;
    int test_num    = 0;

    mesh_router #(
        .ROUTER_X (ROUTER_X),
        .ROUTER_Y (ROUTER_Y)
    ) DUT (
        .clk         (clk),
        .rst_i       (rst_i),
        .in_data_i   (in_data_i),
        .in_last_i   (in_last_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_data_o  (out_data_o),
        .out_last_o  (out_last_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    always #50 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic chan_t expected_port(input coord_t tx, input coord_t ty);
        if (int'(tx) > ROUTER_X) return PORT_EAST;     // X is resolved first
        if (int'(tx) < ROUTER_X) return PORT_WEST;
        if (int'(ty) > ROUTER_Y) return PORT_NORTH;
        if (int'(ty) < ROUTER_Y) return PORT_SOUTH;
        return PORT_LOCAL;
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0d ns: %s is %h, expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic add_packet(input int src, input coord_t tx, input coord_t ty, input int len);
        flit_t data;
        chan_t port;
        port = expected_port(tx, ty);
        for (int i = 0; i < len; i++) begin
            data = flit_t'($random(pkt_seed));
            if (i == 0) begin
                data[HDR_X_LSB +: COORD_W] = tx;
                data[HDR_Y_LSB +: COORD_W] = ty;
                data[SRC_LSB +: 4]         = 4'(src);
            end
            pkt_mem[src][fill_ptr[src]] = {port, (i == len - 1), data};
            fill_ptr[src] = fill_ptr[src] + 1;
            total_flits   = total_flits + 1;
        end
    endtask

    function automatic int rand_len();
        return 1 + int'($random(pkt_seed) & 3);
    endfunction

    task automatic wait_drain();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = 1'b0;
            for (int c = 0; c < CHANNELS; c++) begin
                if (rx_ptr[c] != fill_ptr[c]) busy = 1'b1;
            end
        end
    endtask

    task automatic report_test(input string name);
        test_num++;
        $display("Test %0d %-36s %0d checks, %0d errors",
                 test_num, name, checks - check_mark, errors - err_mark);
        check_mark = checks;
        err_mark   = errors;
    endtask

    // Scoreboard entry point for one output transfer
    task automatic check_output(input int p);
        flit_t                    d;
        logic [CH_W+DATA_WIDTH:0] exp;
        d = out_data_o[p];
        if (expect_hdr) begin
            check_value($sformatf("header route on out_valid_o[%0d]", p), 32'(p),
                        32'(expected_port(d[HDR_X_LSB +: COORD_W], d[HDR_Y_LSB +: COORD_W])));
            cur_src = int'(d[SRC_LSB +: 4]);
        end
        if (cur_src >= CHANNELS || rx_ptr[cur_src] >= fill_ptr[cur_src]) begin
            errors++;
            $display("** Error at %0d ns: flit on output %0d that no source has sent",
                     $time, p);
        end else begin
            exp = pkt_mem[cur_src][rx_ptr[cur_src]];
            check_value($sformatf("out_data_o[%0d]", p), d, exp[DATA_WIDTH-1:0]);
            check_value($sformatf("out_last_o[%0d]", p), 32'(out_last_o[p]),
                        32'(exp[DATA_WIDTH]));
            check_value("output port", 32'(p), 32'(exp[DATA_WIDTH+1 +: CH_W]));
            rx_ptr[cur_src] = rx_ptr[cur_src] + 1;
        end
        expect_hdr = out_last_o[p];     // Next flit on the router starts a packet
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sources and sinks driven at the rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        for (int c = 0; c < CHANNELS; c++) begin
            if (in_accept[c]) send_ptr[c] = send_ptr[c] + 1;
            if (!rst_i && send_ptr[c] < fill_ptr[c]) begin
                in_valid_i[c] <= 1'b1;
                in_data_i[c]  <= pkt_mem[c][send_ptr[c]][DATA_WIDTH-1:0];
                in_last_i[c]  <= pkt_mem[c][send_ptr[c]][DATA_WIDTH];
            end else begin
                in_valid_i[c] <= 1'b0;
            end
        end
        sink_bits = $random(sink_seed);
        if (rand_ready) begin
            out_ready_i <= sink_bits[4:0] | sink_bits[9:5];   // High about 3 of 4 cycles
        end else begin
            out_ready_i <= '1;
        end
    end

    // Monitor samples mid-cycle, where every handshake signal is settled
    always @(negedge clk) begin
        if (rst_i || idle_check) begin
            check_value("out_valid_o", 32'(out_valid_o), 32'(0));
            check_value("in_ready_o", 32'(in_ready_o), 32'({CHANNELS{1'b1}}));
        end
        if (rst_i) begin
            in_accept = '0;
        end else begin
            in_accept = in_valid_i & in_ready_o;
            for (int p = 0; p < CHANNELS; p++) begin
                if (out_valid_o[p] && out_ready_i[p]) check_output(p);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > 20 * total_flits + 200) begin
            $display("Timeout after %0d cycles, the traffic did not drain", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        repeat (2) @(posedge clk);
        rst_i      <= 1'b0;
        idle_check = 1'b1;
        repeat (4) @(posedge clk);
        idle_check = 1'b0;
        report_test("reset and idle state");

        @(negedge clk);
        add_packet(PORT_LOCAL, 2'd1, 2'd1, 3);     // Local
        add_packet(PORT_LOCAL, 2'd3, 2'd1, 4);     // East
        add_packet(PORT_LOCAL, 2'd0, 2'd1, 2);     // West
        add_packet(PORT_LOCAL, 2'd1, 2'd3, 1);     // North
        add_packet(PORT_LOCAL, 2'd1, 2'd0, 4);     // South
        wait_drain();
        report_test("local input to every direction");

        @(negedge clk);
        for (int k = 0; k < 3; k++) begin
            for (int s = 0; s < CHANNELS; s++) begin
                add_packet(s, 2'd3, 2'd2, rand_len());
            end
        end
        wait_drain();
        report_test("all inputs to one output");

        @(negedge clk);
        rand_ready = 1'b1;
        for (int k = 0; k < 30; k++) begin
            for (int s = 0; s < CHANNELS; s++) begin
                add_packet(s, coord_t'($random(pkt_seed)), coord_t'($random(pkt_seed)),
                           rand_len());
            end
        end
        wait_drain();
        rand_ready = 1'b0;
        report_test("random traffic with back-pressure");

        @(negedge clk);
        for (int k = 0; k < 8; k++) begin
            for (int s = 0; s < CHANNELS; s++) begin
                add_packet(s, coord_t'($random(pkt_seed)), coord_t'($random(pkt_seed)),
                           (k % 2 == 0) ? 1 : 2 + int'($unsigned($random(pkt_seed)) % 3));
            end
        end
        wait_drain();
        report_test("single and multi flit packets");

        $display("Summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- mesh_router.f
noc_pkg.sv
flit_fifo.sv
packet_arbiter.sv
xy_route_switch.sv
mesh_router.sv
tb_mesh_router.sv

//--- Makefile
# Verilator build and run for the mesh router testbench
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_mesh_router
FILELIST  ?= mesh_router.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= All tests passed

SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean build run

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)

test: run
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
